// File: src/legPkg.sv
/*
 * LEGv8 core shared definitions
 * decoded instruction classes, ALU operations, condition codes,
 * the decoder's control bundle and the NZCV flag set
 */
package legPkg;

	// architectural register width
	localparam int dataWidth = 64;

	typedef enum logic [3:0] {
		iB,
		iBcond,
		iBL,
		iBR,
		iCBZ,
		iADDI,
		iADDS,
		iSUBS,
		iLDUR,
		iSTUR,
		iNop
	} instrClass;

	typedef enum logic [1:0] {
		aluAdd,
		aluSub,
		aluPassB
	} aluOp;

	// standard ARM condition encodings
	typedef enum logic [3:0] {
		ccEq = 4'h0,
		ccNe = 4'h1,
		ccHs = 4'h2,
		ccLo = 4'h3,
		ccMi = 4'h4,
		ccPl = 4'h5,
		ccVs = 4'h6,
		ccVc = 4'h7,
		ccHi = 4'h8,
		ccLs = 4'h9,
		ccGe = 4'ha,
		ccLt = 4'hb,
		ccGt = 4'hc,
		ccLe = 4'hd,
		ccAl = 4'he
	} condCode;

	typedef struct packed {
		instrClass cls;
		logic reg2Loc;
		logic aluSrcImm;
		aluOp aluFn;
		logic setFlags;
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic branchLink;
	} ctrlSignals;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} nzcvFlags;

endpackage

// File: src/cpuControl.sv
/*
 * LEGv8 instruction decoder
 * matches the 11-bit opcode field against the supported encodings
 * and builds the control bundle; anything unknown becomes a no-op.
 * register and memory write enables stay off while in reset
 */
`timescale 1ns/1ps

module cpuControl
	import legPkg::*;
(
	input  logic        rst,
	input  logic [10:0] opcode,
	output ctrlSignals  ctrl
);

	// opcode slices per instruction format
	logic [5:0] bOp;
	logic [7:0] cbOp;
	logic [9:0] iOp;

	assign bOp = opcode[10:5];
	assign cbOp = opcode[10:3];
	assign iOp = opcode[10:1];

	always_comb begin
		// defined no-op unless a match below
		ctrl = '0;
		ctrl.cls = iNop;
		ctrl.aluFn = aluPassB;

		if (bOp == 6'b000101) begin
			ctrl.cls = iB;
		end else if (cbOp == 8'b01010100) begin
			ctrl.cls = iBcond;
		end else if (bOp == 6'b100101) begin
			// link register gets pc + 4
			ctrl.cls = iBL;
			ctrl.regWrite = 1'b1;
			ctrl.branchLink = 1'b1;
		end else if (opcode == 11'b11010110000) begin
			ctrl.cls = iBR;
		end else if (cbOp == 8'b10110100) begin
			// tested register read through Rt
			ctrl.cls = iCBZ;
			ctrl.reg2Loc = 1'b1;
		end else if (iOp == 10'b1001000100) begin
			ctrl.cls = iADDI;
			ctrl.aluSrcImm = 1'b1;
			ctrl.aluFn = aluAdd;
			ctrl.regWrite = 1'b1;
		end else if (opcode == 11'b10101011000) begin
			ctrl.cls = iADDS;
			ctrl.aluFn = aluAdd;
			ctrl.setFlags = 1'b1;
			ctrl.regWrite = 1'b1;
		end else if (opcode == 11'b11101011000) begin
			ctrl.cls = iSUBS;
			ctrl.aluFn = aluSub;
			ctrl.setFlags = 1'b1;
			ctrl.regWrite = 1'b1;
		end else if (opcode == 11'b11111000010) begin
			ctrl.cls = iLDUR;
			ctrl.aluSrcImm = 1'b1;
			ctrl.aluFn = aluAdd;
			ctrl.regWrite = 1'b1;
			ctrl.memToReg = 1'b1;
		end else if (opcode == 11'b11111000000) begin
			// store data comes from Rt
			ctrl.cls = iSTUR;
			ctrl.reg2Loc = 1'b1;
			ctrl.aluSrcImm = 1'b1;
			ctrl.aluFn = aluAdd;
			ctrl.memWrite = 1'b1;
		end

		// no architectural writes during reset
		if (!rst) begin
			ctrl.regWrite = 1'b0;
			ctrl.memWrite = 1'b0;
		end
	end

endmodule

// File: src/regFile.sv
/*
 * LEGv8 register file
 * 32 x 64-bit registers with two read ports and one write port.
 * X31 reads as zero; the write-back mux picks load data,
 * ALU result or the branch link value
 */
`timescale 1ns/1ps

module regFile
	import legPkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  ctrlSignals           ctrl,
	input  logic [31:0]          instr,
	input  logic [dataWidth-1:0] aluResult,
	input  logic [dataWidth-1:0] dataRdata,
	input  logic [dataWidth-1:0] linkValue,
	output logic [dataWidth-1:0] rdA,
	output logic [dataWidth-1:0] rdB
);

	logic [dataWidth-1:0] regs [32];
	logic [4:0] addrA;
	logic [4:0] addrB;
	logic [4:0] wrAddr;
	logic [dataWidth-1:0] wrData;

	// BR target comes out on the second port
	assign addrA = instr[9:5];
	assign addrB = (ctrl.cls == iBR) ? instr[9:5] :
		ctrl.reg2Loc ? instr[4:0] : instr[20:16];
	assign wrAddr = ctrl.branchLink ? 5'd30 : instr[4:0];

	always_comb begin
		if (ctrl.branchLink) begin
			wrData = linkValue;
		end else if (ctrl.memToReg) begin
			wrData = dataRdata;
		end else begin
			wrData = aluResult;
		end
	end

	// zero register
	assign rdA = (addrA == 5'd31) ? '0 : regs[addrA];
	assign rdB = (addrB == 5'd31) ? '0 : regs[addrB];

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.regWrite && wrAddr != 5'd31) begin
			regs[wrAddr] <= wrData;
		end
	end

endmodule

// File: src/execUnit.sv
/*
 * LEGv8 execute stage
 * builds the immediate, selects operand B, and adds, subtracts
 * or passes B through. Produces NZCV for the flag-setting ops
 * and the zero test used by CBZ
 */
`timescale 1ns/1ps

module execUnit
	import legPkg::*;
(
	input  ctrlSignals           ctrl,
	input  logic [31:0]          instr,
	input  logic [dataWidth-1:0] rdA,
	input  logic [dataWidth-1:0] rdB,
	output logic [dataWidth-1:0] aluResult,
	output nzcvFlags             aluFlags,
	output logic                 isZero
);

	logic [dataWidth-1:0] immVal;
	logic [dataWidth-1:0] opB;
	logic [dataWidth:0] wideSum;
	logic carry;
	logic overflow;

	// imm12 zero-extended for ADDI, imm9 sign-extended for loads and stores
	assign immVal = (ctrl.cls == iADDI) ?
		{{(dataWidth-12){1'b0}}, instr[21:10]} :
		{{(dataWidth-9){instr[20]}}, instr[20:12]};

	assign opB = ctrl.aluSrcImm ? immVal : rdB;

	always_comb begin
		wideSum = '0;
		carry = 1'b0;
		overflow = 1'b0;
		aluResult = opB;
		unique case (ctrl.aluFn)
			aluAdd: begin
				wideSum = {1'b0, rdA} + {1'b0, opB};
				aluResult = wideSum[dataWidth-1:0];
				carry = wideSum[dataWidth];
				overflow = (rdA[dataWidth-1] == opB[dataWidth-1]) &&
					(aluResult[dataWidth-1] != rdA[dataWidth-1]);
			end
			aluSub: begin
				// carry out means no borrow
				wideSum = {1'b0, rdA} + {1'b0, ~opB} + 1'b1;
				aluResult = wideSum[dataWidth-1:0];
				carry = wideSum[dataWidth];
				overflow = (rdA[dataWidth-1] != opB[dataWidth-1]) &&
					(aluResult[dataWidth-1] != rdA[dataWidth-1]);
			end
			default: begin
				aluResult = opB;
			end
		endcase
	end

	assign aluFlags.n = aluResult[dataWidth-1];
	assign aluFlags.z = (aluResult == '0);
	assign aluFlags.c = carry;
	assign aluFlags.v = overflow;

	// CBZ looks at the register itself
	assign isZero = (rdB == '0);

endmodule

// File: src/branchUnit.sv
/*
 * LEGv8 branch unit
 * holds the PC and the NZCV flags register, evaluates the
 * B.cond condition and selects the next PC. Also supplies
 * PC + 4 as the link value for BL
 */
`timescale 1ns/1ps

module branchUnit
	import legPkg::*;
#(
	parameter logic [dataWidth-1:0] resetPc = '0
) (
	input  logic                 clk,
	input  logic                 rst,
	input  ctrlSignals           ctrl,
	input  logic [31:0]          instr,
	input  nzcvFlags             aluFlags,
	input  logic                 isZero,
	input  logic [dataWidth-1:0] rdB,
	output logic [dataWidth-1:0] pc,
	output logic [dataWidth-1:0] linkValue
);

	nzcvFlags flags;
	condCode cond;
	logic condMet;
	logic [dataWidth-1:0] offset26;
	logic [dataWidth-1:0] offset19;
	logic [dataWidth-1:0] nextPc;

	// word offsets scaled to bytes
	assign offset26 = {{(dataWidth-28){instr[25]}}, instr[25:0], 2'b00};
	assign offset19 = {{(dataWidth-21){instr[23]}}, instr[23:5], 2'b00};
	assign linkValue = pc + 64'd4;
	assign cond = condCode'(instr[3:0]);

	always_comb begin
		unique case (cond)
			ccEq: condMet = flags.z;
			ccNe: condMet = !flags.z;
			ccHs: condMet = flags.c;
			ccLo: condMet = !flags.c;
			ccMi: condMet = flags.n;
			ccPl: condMet = !flags.n;
			ccVs: condMet = flags.v;
			ccVc: condMet = !flags.v;
			ccHi: condMet = flags.c && !flags.z;
			ccLs: condMet = !flags.c || flags.z;
			ccGe: condMet = (flags.n == flags.v);
			ccLt: condMet = (flags.n != flags.v);
			ccGt: condMet = !flags.z && (flags.n == flags.v);
			ccLe: condMet = flags.z || (flags.n != flags.v);
			// AL, and NV behaves the same
			default: condMet = 1'b1;
		endcase
	end

	always_comb begin
		unique case (ctrl.cls)
			iB, iBL: nextPc = pc + offset26;
			iBcond: nextPc = condMet ? pc + offset19 : linkValue;
			iCBZ: nextPc = isZero ? pc + offset19 : linkValue;
			iBR: nextPc = rdB;
			default: nextPc = linkValue;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			pc <= resetPc;
			flags <= '0;
		end else begin
			pc <= nextPc;
			if (ctrl.setFlags) begin
				flags <= aluFlags;
			end
		end
	end

endmodule

// File: src/legCore.sv
/*
 * LEGv8 single-cycle core
 * ties the decoder, register file, execute logic and branch
 * unit to combinational instruction and data memory ports
 */
`timescale 1ns/1ps

module legCore
	import legPkg::*;
#(
	parameter logic [dataWidth-1:0] resetPc = '0
) (
	input  logic                 clk,
	input  logic                 rst,
	output logic [dataWidth-1:0] instrAddr,
	input  logic [31:0]          instr,
	output logic [dataWidth-1:0] dataAddr,
	output logic [dataWidth-1:0] dataWdata,
	output logic                 dataWe,
	input  logic [dataWidth-1:0] dataRdata
);

	ctrlSignals ctrl;
	logic [dataWidth-1:0] rdA;
	logic [dataWidth-1:0] rdB;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] linkValue;
	nzcvFlags aluFlags;
	logic isZero;

	assign dataAddr = aluResult;
	assign dataWdata = rdB;
	assign dataWe = ctrl.memWrite;

	cpuControl uControl (
		.rst   (rst),
		.opcode(instr[31:21]),
		.ctrl  (ctrl)
	);

	regFile uRegs (
		.clk      (clk),
		.rst      (rst),
		.ctrl     (ctrl),
		.instr    (instr),
		.aluResult(aluResult),
		.dataRdata(dataRdata),
		.linkValue(linkValue),
		.rdA      (rdA),
		.rdB      (rdB)
	);

	execUnit uExec (
		.ctrl     (ctrl),
		.instr    (instr),
		.rdA      (rdA),
		.rdB      (rdB),
		.aluResult(aluResult),
		.aluFlags (aluFlags),
		.isZero   (isZero)
	);

	branchUnit #(
		.resetPc(resetPc)
	) uBranch (
		.clk      (clk),
		.rst      (rst),
		.ctrl     (ctrl),
		.instr    (instr),
		.aluFlags (aluFlags),
		.isZero   (isZero),
		.rdB      (rdB),
		.pc       (instrAddr),
		.linkValue(linkValue)
	);

endmodule

// File: verification/legCore_asserts.sv
/*
 * LEGv8 core port checks
 * concurrent assertions bound to the core top level
 */
`timescale 1ns/1ps

module legCore_asserts (
	input logic        clk,
	input logic        rst,
	input logic        dataWe,
	input logic [63:0] instrAddr
);

	// no store may leave the core while in reset
	assert property (@(posedge clk) !rst |-> !dataWe)
		else $error("data write enable active during reset");

	// fetch address stays on a word boundary once out of reset
	assert property (@(posedge clk) rst |-> (instrAddr[1:0] == 2'b00))
		else $error("instruction address not word aligned");

	assert property (@(posedge clk) rst |-> !$isunknown(dataWe))
		else $error("data write enable unknown after reset");

endmodule

bind legCore legCore_asserts uAsserts (
	.clk      (clk),
	.rst      (rst),
	.dataWe   (dataWe),
	.instrAddr(instrAddr)
);

// File: verification/legCore_tb.sv
/*
 * LEGv8 core testbench
 * models instruction and data memory, builds a test program,
 * steps a reference model each cycle and compares PC and stores
 */
`timescale 1ns/1ps

module legCore_tb
	import legPkg::*;
();

	typedef struct packed {
		logic valid;
		logic [63:0] addr;
		logic [63:0] data;
	} storeExp;

	localparam logic [63:0] resetPc = 64'h0;
	localparam logic [10:0] opAdds = 11'b10101011000;
	localparam logic [10:0] opSubs = 11'b11101011000;
	localparam logic [10:0] opLdur = 11'b11111000010;
	localparam logic [10:0] opStur = 11'b11111000000;

	logic clk;
	logic rst;
	logic [63:0] instrAddr;
	logic [31:0] instr;
	logic [63:0] dataAddr;
	logic [63:0] dataWdata;
	logic dataWe;
	logic [63:0] dataRdata;

	logic [31:0] imem [1024];
	logic [63:0] dmem [512];

	// reference architectural state
	logic [63:0] refRegs [32];
	logic [63:0] refMem [512];
	logic [63:0] refPc;
	nzcvFlags refFlags;

	integer seed;
	int progLen;
	int maxCycles;
	int cycleCount;
	int errors;
	logic finished;

	legCore #(
		.resetPc(resetPc)
	) uut (
		.clk      (clk),
		.rst      (rst),
		.instrAddr(instrAddr),
		.instr    (instr),
		.dataAddr (dataAddr),
		.dataWdata(dataWdata),
		.dataWe   (dataWe),
		.dataRdata(dataRdata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// fetch lands 2 ns after the edge once out of reset
	always @(posedge clk) begin
		#2;
		if (rst) begin
			instr = imem[instrAddr[11:2]];
		end
	end

	assign dataRdata = dmem[dataAddr[11:3]];

	always @(negedge clk) begin
		if (dataWe) begin
			dmem[dataAddr[11:3]] = dataWdata;
		end
	end

	function automatic logic [31:0] encB(input logic [25:0] off);
		return {6'b000101, off};
	endfunction

	function automatic logic [31:0] encBl(input logic [25:0] off);
		return {6'b100101, off};
	endfunction

	function automatic logic [31:0] encBcond(input logic [18:0] off, input logic [3:0] cc);
		return {8'b01010100, off, 1'b0, cc};
	endfunction

	function automatic logic [31:0] encCbz(input logic [18:0] off, input logic [4:0] rt);
		return {8'b10110100, off, rt};
	endfunction

	function automatic logic [31:0] encBr(input logic [4:0] rn);
		return {11'b11010110000, 5'b11111, 6'b000000, rn, 5'b00000};
	endfunction

	function automatic logic [31:0] encAddi(input logic [11:0] imm, input logic [4:0] rn,
		input logic [4:0] rd);
		return {10'b1001000100, imm, rn, rd};
	endfunction

	function automatic logic [31:0] encReg(input logic [10:0] op, input logic [4:0] rm,
		input logic [4:0] rn, input logic [4:0] rd);
		return {op, rm, 6'b000000, rn, rd};
	endfunction

	function automatic logic [31:0] encMem(input logic [10:0] op, input logic [8:0] off,
		input logic [4:0] rn, input logic [4:0] rt);
		return {op, off, 2'b00, rn, rt};
	endfunction

	task automatic emit(input logic [31:0] ins);
		imem[progLen] = ins;
		progLen++;
	endtask

	// store through X27, which then moves on by one word
	task automatic storeReg(input logic [4:0] rt);
		emit(encMem(opStur, 9'd0, 5'd27, rt));
		emit(encAddi(12'd8, 5'd27, 5'd27));
	endtask

	task automatic buildProgram();
		logic [5:0] o1;
		logic [5:0] o2;
		progLen = 0;
		emit(encAddi(12'd512, 5'd31, 5'd28));
		emit(encAddi(12'd1024, 5'd31, 5'd27));
		// arithmetic on random immediates
		for (int k = 1; k <= 4; k++) begin
			emit(encAddi(12'($random(seed)), 5'd31, 5'(k)));
		end
		emit(encReg(opAdds, 5'd2, 5'd1, 5'd5));
		emit(encReg(opSubs, 5'd4, 5'd3, 5'd6));
		emit(encAddi(12'($random(seed)), 5'd6, 5'd7));
		for (int k = 1; k <= 7; k++) begin
			storeReg(5'(k));
		end
		// loads from random words, positive and negative offsets
		for (int k = 0; k < 6; k++) begin
			o1 = 6'($random(seed));
			emit(encMem(opLdur, {o1, 3'b000}, 5'd28, 5'(8 + k)));
			storeReg(5'(8 + k));
		end
		emit(encReg(opAdds, 5'd9, 5'd8, 5'd14));
		storeReg(5'd14);
		// every condition after a SUBS, some with equal operands
		for (int cc = 0; cc < 15; cc++) begin
			o1 = 6'($random(seed));
			o2 = (cc % 3 == 0) ? o1 : 6'($random(seed));
			emit(encMem(opLdur, {o1, 3'b000}, 5'd28, 5'd10));
			emit(encMem(opLdur, {o2, 3'b000}, 5'd28, 5'd11));
			emit(encReg(opSubs, 5'd11, 5'd10, 5'd12));
			emit(encBcond(19'd2, 4'(cc)));
			emit(encAddi(12'd1, 5'd13, 5'd13));
		end
		storeReg(5'd13);
		// B over a marker, then a BL call returning through BR X30
		emit(encB(26'd2));
		emit(encAddi(12'd1, 5'd15, 5'd15));
		emit(encBl(26'd4));
		storeReg(5'd30);
		emit(encB(26'd3));
		emit(encAddi(12'd5, 5'd15, 5'd15));
		emit(encBr(5'd30));
		// CBZ taken on zero, not taken on X15
		emit(encAddi(12'd0, 5'd31, 5'd16));
		emit(encCbz(19'd2, 5'd16));
		emit(encAddi(12'd1, 5'd17, 5'd17));
		emit(encCbz(19'd2, 5'd15));
		emit(encAddi(12'd2, 5'd17, 5'd17));
		storeReg(5'd17);
		storeReg(5'd15);
		// undefined encodings
		emit(32'h00000000);
		emit(32'hffffffff);
		emit(32'h8b000000);
		emit(encB(26'd0));
	endtask

	function automatic logic [63:0] readReg(input logic [4:0] idx);
		return (idx == 5'd31) ? 64'd0 : refRegs[idx];
	endfunction

	function automatic void setReg(input logic [4:0] idx, input logic [63:0] val);
		if (idx != 5'd31) begin
			refRegs[idx] = val;
		end
	endfunction

	function automatic logic condHolds(input logic [3:0] cc);
		logic base;
		case (cc[3:1])
			3'b000: base = refFlags.z;
			3'b001: base = refFlags.c;
			3'b010: base = refFlags.n;
			3'b011: base = refFlags.v;
			3'b100: base = refFlags.c && !refFlags.z;
			3'b101: base = (refFlags.n == refFlags.v);
			3'b110: base = !refFlags.z && (refFlags.n == refFlags.v);
			default: base = 1'b1;
		endcase
		// odd codes are the inverse, except the always code
		if (cc[0] && cc != 4'hf) begin
			return !base;
		end
		return base;
	endfunction

	function automatic storeExp refStep(input logic [31:0] ins);
		storeExp res;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] r;
		logic [64:0] wide;
		logic [63:0] next;
		res = '0;
		a = readReg(ins[9:5]);
		b = readReg(ins[20:16]);
		next = refPc + 64'd4;
		if (ins[31:26] == 6'b000101) begin
			next = refPc + {{36{ins[25]}}, ins[25:0], 2'b00};
		end else if (ins[31:26] == 6'b100101) begin
			setReg(5'd30, refPc + 64'd4);
			next = refPc + {{36{ins[25]}}, ins[25:0], 2'b00};
		end else if (ins[31:24] == 8'b01010100) begin
			if (condHolds(ins[3:0])) begin
				next = refPc + {{43{ins[23]}}, ins[23:5], 2'b00};
			end
		end else if (ins[31:24] == 8'b10110100) begin
			if (readReg(ins[4:0]) == 64'd0) begin
				next = refPc + {{43{ins[23]}}, ins[23:5], 2'b00};
			end
		end else if (ins[31:21] == 11'b11010110000) begin
			next = a;
		end else if (ins[31:22] == 10'b1001000100) begin
			setReg(ins[4:0], a + {52'd0, ins[21:10]});
		end else if (ins[31:21] == opAdds) begin
			wide = {1'b0, a} + {1'b0, b};
			r = wide[63:0];
			setReg(ins[4:0], r);
			refFlags.n = r[63];
			refFlags.z = (r == 64'd0);
			refFlags.c = wide[64];
			refFlags.v = (a[63] & b[63] & ~r[63]) | (~a[63] & ~b[63] & r[63]);
		end else if (ins[31:21] == opSubs) begin
			r = a - b;
			setReg(ins[4:0], r);
			refFlags.n = r[63];
			refFlags.z = (r == 64'd0);
			refFlags.c = (a >= b);
			refFlags.v = (a[63] & ~b[63] & ~r[63]) | (~a[63] & b[63] & r[63]);
		end else if (ins[31:21] == opLdur) begin
			r = a + {{55{ins[20]}}, ins[20:12]};
			setReg(ins[4:0], refMem[r[11:3]]);
		end else if (ins[31:21] == opStur) begin
			res.valid = 1'b1;
			res.addr = a + {{55{ins[20]}}, ins[20:12]};
			res.data = readReg(ins[4:0]);
			refMem[res.addr[11:3]] = res.data;
		end
		refPc = next;
		return res;
	endfunction

	task automatic checkValue(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h expected %h at pc %h", name, got, exp, instrAddr);
		end
	endtask

	always @(negedge clk) begin : compare
		storeExp expStore;
		logic [63:0] pcBefore;
		if (!rst) begin
			checkValue("dataWe", 64'(dataWe), 64'd0);
		end else if (!finished) begin
			pcBefore = refPc;
			checkValue("instrAddr", instrAddr, refPc);
			expStore = refStep(imem[refPc[11:2]]);
			checkValue("dataWe", 64'(dataWe), 64'(expStore.valid));
			if (expStore.valid) begin
				checkValue("dataAddr", dataAddr, expStore.addr);
				checkValue("dataWdata", dataWdata, expStore.data);
			end
			// final branch to itself
			if (refPc == pcBefore) begin
				finished = 1'b1;
			end
		end
	end

	initial begin
		rst = 1'b0;
		// a store sits on the bus for the whole reset
		instr = encMem(opStur, 9'd0, 5'd31, 5'd31);
		seed = 94;
		errors = 0;
		cycleCount = 0;
		finished = 1'b0;
		for (int i = 0; i < 1024; i++) begin
			imem[i] = encB(26'd0);
		end
		for (int i = 0; i < 512; i++) begin
			dmem[i] = {$random(seed), $random(seed)};
			refMem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++) begin
			refRegs[i] = 64'd0;
		end
		refPc = resetPc;
		refFlags = '0;
		buildProgram();
		maxCycles = 2 * progLen + 20;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b1;
		instr = imem[resetPc[11:2]];
		while (!finished && cycleCount <= maxCycles) begin
			@(posedge clk);
			cycleCount++;
		end
		if (!finished) begin
			errors++;
			$display("timeout: program did not reach its final branch in %0d cycles", maxCycles);
		end
		$display("run complete after %0d cycles, %0d errors", cycleCount, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: legCore.f
src/legPkg.sv
src/cpuControl.sv
src/regFile.sv
src/execUnit.sv
src/branchUnit.sv
src/legCore.sv
verification/legCore_asserts.sv
verification/legCore_tb.sv

// File: Makefile
SIM      = verilator
TOP      = legCore_tb
FILELIST = legCore.f
FLAGS    = --binary --timing --assert -j 0
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "Test FAILED" $(LOG) && grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
